/* hw/trace_pkg.sv */
`default_nettype none

package trace_pkg;

    localparam int unsigned xlen        = 32;
    localparam int unsigned queue_depth = 4;
    localparam int unsigned queue_aw    = 2;
    localparam int unsigned ts_width    = 64;
    localparam int unsigned lost_width  = 16;

    typedef enum logic [2:0] {
        INST,
        LOAD,
        STORE,
        REG,
        CSR,
        TRAP,
        HALT,
        LOST
    } rec_kind_e;

    // Retire port as presented by the core.
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic [1:0]      prv;
        logic            dbg;
        logic            rd_wr;
        logic [4:0]      rd_addr;
        logic [xlen-1:0] rd_data;
        logic            csr_wr;
        logic [11:0]     csr_addr;
        logic [xlen-1:0] csr_wdata;
        logic            mem_req;
        logic            mem_wr;
        logic [3:0]      mem_byte;
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] mem_rdata;
        logic [xlen-1:0] mem_wdata;
        logic            trap;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtval;
        logic            halted;
    } retire_t;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     inst;
        logic [1:0]          prv;
        logic                dbg;
        logic                rd_wr;
        logic [4:0]          rd_addr;
        logic [xlen-1:0]     rd_data;   // Zero for x0.
        logic                csr_wr;
        logic [11:0]         csr_addr;
        logic [xlen-1:0]     csr_wdata;
        logic                mem_req;
        logic                mem_wr;
        logic [3:0]          mem_byte;
        logic [xlen-1:0]     mem_addr;
        logic [xlen-1:0]     mem_data;  // Masked read or write data.
        logic                trap;
        logic [xlen-1:0]     mcause;
        logic [xlen-1:0]     mtval;
        logic                halt_enter;
        logic                halt_leave;
        logic [ts_width-1:0] timestamp;
    } retire_evt_t;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] data;
    } rec_pair_t;

    typedef struct packed {
        logic            is_irq;
        logic [xlen-2:0] code;
        logic [xlen-1:0] tval;
    } rec_trap_t;

    typedef union packed {
        rec_pair_t pair;
        rec_trap_t trap;   // TRAP records only.
    } trace_payload_u;

    typedef struct packed {
        rec_kind_e      kind;
        logic [4:0]     tag;
        trace_payload_u payload;
    } trace_rec_t;

endpackage

`default_nettype wire

/* hw/retire_capture.sv */
`default_nettype none

module retire_capture (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire trace_pkg::retire_t             retire,
    input  wire [trace_pkg::ts_width-1:0]       timestamp,
    input  wire                                 full,
    output trace_pkg::retire_evt_t              evt,
    output logic                                evt_push,
    output logic                                drop_pulse
);

    trace_pkg::retire_t                 ret_q;
    logic [trace_pkg::ts_width-1:0]     ts_q;
    logic                               halted_prev;
    logic                               halt_enter;
    logic                               halt_leave;
    logic                               has_evt;
    logic [trace_pkg::xlen-1:0]         mem_sel;
    logic [trace_pkg::xlen-1:0]         mem_masked;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ret_q       <= '0;
            halted_prev <= 1'b0;
        end else begin
            ret_q       <= retire;
            halted_prev <= ret_q.halted;   // Level of the previous sample.
        end
    end

    always_ff @(posedge clk) begin
        ts_q <= timestamp;
    end

    assign halt_enter = ret_q.halted & ~halted_prev;
    assign halt_leave = ~ret_q.halted & halted_prev;
    assign has_evt    = halt_enter | halt_leave | ret_q.valid | ret_q.rd_wr |
                        ret_q.csr_wr | ret_q.trap;

    always_comb begin
        mem_sel = ret_q.mem_wr ? ret_q.mem_wdata : ret_q.mem_rdata;
        for (int i = 0; i < 4; i++) begin
            mem_masked[8*i +: 8] = ret_q.mem_byte[i] ? mem_sel[8*i +: 8] : 8'h00;
        end
    end

    always_comb begin
        evt.valid      = ret_q.valid;
        evt.pc         = ret_q.pc;
        evt.inst       = ret_q.inst;
        evt.prv        = ret_q.prv;
        evt.dbg        = ret_q.dbg;
        evt.rd_wr      = ret_q.rd_wr;
        evt.rd_addr    = ret_q.rd_addr;
        evt.rd_data    = (ret_q.rd_addr == 5'd0) ? '0 : ret_q.rd_data;
        evt.csr_wr     = ret_q.csr_wr;
        evt.csr_addr   = ret_q.csr_addr;
        evt.csr_wdata  = ret_q.csr_wdata;
        evt.mem_req    = ret_q.mem_req;
        evt.mem_wr     = ret_q.mem_wr;
        evt.mem_byte   = ret_q.mem_byte;
        evt.mem_addr   = ret_q.mem_addr;
        evt.mem_data   = mem_masked;
        evt.trap       = ret_q.trap;
        evt.mcause     = ret_q.mcause;
        evt.mtval      = ret_q.mtval;
        evt.halt_enter = halt_enter;
        evt.halt_leave = halt_leave;
        evt.timestamp  = ts_q;
    end

    assign evt_push   = has_evt & ~full;
    assign drop_pulse = has_evt & full;   // Counted, never queued.

endmodule

`default_nettype wire

/* hw/event_queue.sv */
`default_nettype none

module event_queue (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         push,
    input  wire trace_pkg::retire_evt_t din,
    input  wire                         pop,
    output trace_pkg::retire_evt_t      head,
    output logic                        empty,
    output logic                        full
);

    trace_pkg::retire_evt_t             mem [trace_pkg::queue_depth];
    logic [trace_pkg::queue_aw-1:0]     wr_ptr;
    logic [trace_pkg::queue_aw-1:0]     rd_ptr;
    logic [trace_pkg::queue_aw:0]       count;
    logic                               do_push;
    logic                               do_pop;

    assign empty   = (count == '0);
    assign full    = (32'(count) == trace_pkg::queue_depth);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth.
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{trace_pkg::queue_aw{1'b0}}, do_push}
                           - {{trace_pkg::queue_aw{1'b0}}, do_pop};
        end
    end

endmodule

`default_nettype wire

/* hw/trace_counters.sv */
`default_nettype none

module trace_counters (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 drop_pulse,
    input  wire                                 lost_clear,
    output logic [trace_pkg::ts_width-1:0]      timestamp,
    output logic [trace_pkg::lost_width-1:0]    lost_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lost_count <= '0;
        end else if (lost_clear) begin
            lost_count <= drop_pulse ? {{(trace_pkg::lost_width-1){1'b0}}, 1'b1} : '0;
        end else if (drop_pulse && lost_count != '1) begin
            lost_count <= lost_count + 1'b1;   // Saturates at all ones.
        end
    end

endmodule

`default_nettype wire

/* hw/record_sequencer.sv */
`default_nettype none

module record_sequencer (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire trace_pkg::retire_evt_t         head,
    input  wire                                 empty,
    input  wire [trace_pkg::lost_width-1:0]     lost_count,
    output logic                                pop,
    output logic                                lost_clear,
    output trace_pkg::trace_rec_t               out_rec,
    output logic                                out_valid,
    input  wire                                 out_ready
);

    typedef enum logic [2:0] {
        IDLE,
        LOST,
        HALT,
        INST,
        MEM,
        REG,
        CSR,
        TRAP
    } state_e;

    state_e     state;
    state_e     nxt;
    logic [7:1] cond;
    logic       xfer;

    // Indexed by state encoding.
    assign cond[1] = (lost_count != '0);
    assign cond[2] = head.halt_enter | head.halt_leave;
    assign cond[3] = head.valid;
    assign cond[4] = head.valid & head.mem_req;
    assign cond[5] = head.rd_wr;
    assign cond[6] = head.csr_wr;
    assign cond[7] = head.trap;

    always_comb begin
        nxt = IDLE;
        for (int i = 7; i >= 1; i--) begin
            if (cond[i] && i > int'(state)) nxt = state_e'(3'(i));   // Lowest wins.
        end
    end

    assign out_valid  = (state != IDLE);
    assign xfer       = out_valid & out_ready;
    assign lost_clear = xfer & (state == LOST);
    assign pop        = xfer && nxt == IDLE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else if (state == IDLE) begin
            if (!empty) state <= nxt;
        end else if (xfer) begin
            state <= nxt;
        end
    end

    always_comb begin
        out_rec = '0;
        case (state)
            LOST: begin
                out_rec.kind              = trace_pkg::LOST;
                out_rec.payload.pair.data = {{(trace_pkg::xlen-trace_pkg::lost_width){1'b0}},
                                             lost_count};
            end
            HALT: begin
                out_rec.kind              = trace_pkg::HALT;
                out_rec.tag               = {4'b0, head.halt_enter};
                out_rec.payload.pair.addr = head.timestamp[63:32];
                out_rec.payload.pair.data = head.timestamp[31:0];
            end
            INST: begin
                out_rec.kind              = trace_pkg::INST;
                out_rec.tag               = {2'b0, head.dbg, head.prv};
                out_rec.payload.pair.addr = head.pc;
                out_rec.payload.pair.data = head.inst;
            end
            MEM: begin
                out_rec.kind              = head.mem_wr ? trace_pkg::STORE : trace_pkg::LOAD;
                out_rec.tag               = {1'b0, head.mem_byte};
                out_rec.payload.pair.addr = {head.mem_addr[31:2], 2'b00};
                out_rec.payload.pair.data = head.mem_data;
            end
            REG: begin
                out_rec.kind              = trace_pkg::REG;
                out_rec.tag               = head.rd_addr;
                out_rec.payload.pair.data = head.rd_data;
            end
            CSR: begin
                out_rec.kind              = trace_pkg::CSR;
                out_rec.payload.pair.addr = {20'b0, head.csr_addr};
                out_rec.payload.pair.data = head.csr_wdata;
            end
            TRAP: begin
                out_rec.kind              = trace_pkg::TRAP;
                out_rec.payload.trap.is_irq = head.mcause[31];   // Interrupt bit.
                out_rec.payload.trap.code   = head.mcause[30:0];
                out_rec.payload.trap.tval   = head.mtval;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* hw/trace_port.sv */
`default_nettype none

module trace_port (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire trace_pkg::trace_rec_t  in_rec,
    input  wire                         in_valid,
    output logic                        in_ready,
    output logic                        trace_req,
    input  wire                         trace_ack,
    output trace_pkg::trace_rec_t       trace_rec
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_ACK_LOW
    } state_e;

    state_e state;

    assign in_ready  = (state == IDLE) & ~trace_ack;
    assign trace_req = (state == REQ);

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) trace_rec <= in_rec;   // Held through the handshake.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:         if (in_valid && in_ready) state <= REQ;
                REQ:          if (trace_ack) state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!trace_ack) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/trace_top.sv */
`default_nettype none

module trace_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire trace_pkg::retire_t     retire,
    output logic                        trace_req,
    input  wire                         trace_ack,
    output trace_pkg::trace_rec_t       trace_rec
);

    trace_pkg::retire_evt_t             evt;
    trace_pkg::retire_evt_t             head;
    logic                               evt_push;
    logic                               drop_pulse;
    logic                               full;
    logic                               empty;
    logic                               pop;
    logic                               lost_clear;
    logic [trace_pkg::ts_width-1:0]     timestamp;
    logic [trace_pkg::lost_width-1:0]   lost_count;
    trace_pkg::trace_rec_t              out_rec;
    logic                               out_valid;
    logic                               out_ready;

    retire_capture retire_capture_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .retire     (retire),
        .timestamp  (timestamp),
        .full       (full),
        .evt        (evt),
        .evt_push   (evt_push),
        .drop_pulse (drop_pulse)
    );

    event_queue event_queue_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (evt_push),
        .din   (evt),
        .pop   (pop),
        .head  (head),
        .empty (empty),
        .full  (full)
    );

    trace_counters trace_counters_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .drop_pulse (drop_pulse),
        .lost_clear (lost_clear),
        .timestamp  (timestamp),
        .lost_count (lost_count)
    );

    record_sequencer record_sequencer_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (head),
        .empty      (empty),
        .lost_count (lost_count),
        .pop        (pop),
        .lost_clear (lost_clear),
        .out_rec    (out_rec),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    trace_port trace_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_rec    (out_rec),
        .in_valid  (out_valid),
        .in_ready  (out_ready),
        .trace_req (trace_req),
        .trace_ack (trace_ack),
        .trace_rec (trace_rec)
    );

endmodule

`default_nettype wire

/* tests/trace_props.sv */
`default_nettype none

module trace_props (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         trace_req,
    input  wire                         trace_ack,
    input  wire trace_pkg::trace_rec_t  trace_rec,
    input  wire                         push,
    input  wire                         pop
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [trace_pkg::queue_aw:0] fill;   // Queue occupancy seen from outside.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill <= '0;
        end else begin
            fill <= fill + {{trace_pkg::queue_aw{1'b0}}, push}
                         - {{trace_pkg::queue_aw{1'b0}}, pop && fill != '0};
        end
    end

    req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        trace_req && !trace_ack |=> trace_req)
        else $error("trace_req dropped before trace_ack rose");

    rec_stable_in_req: assert property (@(posedge clk) disable iff (!rst_n)
        trace_req |=> !trace_req || $stable(trace_rec))
        else $error("trace_rec changed while trace_req was high");

    no_req_while_ack: assert property (@(posedge clk) disable iff (!rst_n)
        trace_ack && !trace_req |=> !trace_req)
        else $error("trace_req rose while trace_ack was still high");

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> 32'(fill) < trace_pkg::queue_depth)
        else $error("event queue pushed while full");

endmodule

`default_nettype wire

/* tests/trace_checker.sv */
`default_nettype none

module trace_checker (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire trace_pkg::retire_t     retire,
    input  wire                         trace_req,
    input  wire                         trace_ack,
    input  wire trace_pkg::trace_rec_t  trace_rec
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [71:0] exp_q [$];
    logic [63:0] edge_cnt;
    logic        halted_prev;
    logic        taken;
    string       test_name = "none";
    bit          stall_mode = 1'b0;
    bit          active = 1'b0;
    bit          last_was_lost = 1'b0;
    int          events_driven = 0;
    int          inst_seen = 0;
    int          lost_sum = 0;
    int          test_errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          stray_errors = 0;

    function automatic logic [71:0] make_rec(input logic [2:0] kind, input logic [4:0] tag,
                                             input logic [31:0] hi, input logic [31:0] lo);
        return {kind, tag, hi, lo};
    endfunction

    function automatic logic [31:0] mask_bytes(input logic [31:0] d, input logic [3:0] m);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            r[8*i +: 8] = m[i] ? d[8*i +: 8] : 8'h00;
        end
        return r;
    endfunction

    // Expected records of one sampled retire, in emission order.
    task automatic predict(input trace_pkg::retire_t r, input logic [63:0] ts);
        logic        enter;
        logic        leave;
        logic [31:0] mdata;
        enter = r.halted & ~halted_prev;
        leave = ~r.halted & halted_prev;
        halted_prev = r.halted;
        if (!(enter || leave || r.valid || r.rd_wr || r.csr_wr || r.trap)) return;
        events_driven++;
        if (stall_mode) return;
        if (enter || leave)
            exp_q.push_back(make_rec(trace_pkg::HALT, {4'b0, enter}, ts[63:32], ts[31:0]));
        if (r.valid)
            exp_q.push_back(make_rec(trace_pkg::INST, {2'b0, r.dbg, r.prv}, r.pc, r.inst));
        if (r.valid && r.mem_req) begin
            mdata = mask_bytes(r.mem_wr ? r.mem_wdata : r.mem_rdata, r.mem_byte);
            exp_q.push_back(make_rec(r.mem_wr ? trace_pkg::STORE : trace_pkg::LOAD,
                                     {1'b0, r.mem_byte}, {r.mem_addr[31:2], 2'b00}, mdata));
        end
        if (r.rd_wr)
            exp_q.push_back(make_rec(trace_pkg::REG, r.rd_addr, 32'h0,
                                     (r.rd_addr == 5'd0) ? 32'h0 : r.rd_data));
        if (r.csr_wr)
            exp_q.push_back(make_rec(trace_pkg::CSR, 5'd0, {20'h0, r.csr_addr}, r.csr_wdata));
        if (r.trap)
            exp_q.push_back(make_rec(trace_pkg::TRAP, 5'd0, {r.mcause[31], r.mcause[30:0]},
                                     r.mtval));
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", test_name, msg);
        if (active) test_errors++;
        else stray_errors++;
    endtask

    task automatic observe(input logic [71:0] rec);
        logic [71:0] exp;
        if (!active) begin
            $display("Record %h arrived outside any test", rec);
            stray_errors++;
            return;
        end
        if (stall_mode) begin
            if (rec[71:69] == trace_pkg::LOST) begin
                if (rec[68:32] !== '0) report_problem("LOST record has a nonzero tag or addr");
                if (last_was_lost) report_problem("two LOST records in a row");
                lost_sum += int'(rec[31:0]);
                last_was_lost = 1'b1;
            end else begin
                if (rec[71:69] == trace_pkg::INST) inst_seen++;
                last_was_lost = 1'b0;
            end
            return;
        end
        if (exp_q.size() == 0) begin
            $display("Error %s: expected no record, actual %h", test_name, rec);
            test_errors++;
            return;
        end
        exp = exp_q.pop_front();
        if (rec !== exp) begin
            $display("Error %s: expected %h, actual %h", test_name, exp, rec);
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            edge_cnt = '0;
            halted_prev = 1'b0;
            taken = 1'b0;
        end else begin
            predict(retire, edge_cnt);   // Timestamp is the count before this edge.
            edge_cnt = edge_cnt + 64'd1;
            if (trace_req && trace_ack && !taken) begin
                taken = 1'b1;
                observe(trace_rec);
            end else if (!trace_req) begin
                taken = 1'b0;
            end
        end
    end

    task automatic start_test(input string name, input bit stall);
        test_name = name;
        stall_mode = stall;
        active = 1'b1;
        last_was_lost = 1'b0;
        events_driven = 0;
        inst_seen = 0;
        lost_sum = 0;
        test_errors = 0;
    endtask

    function automatic bit records_done();
        if (stall_mode) return (inst_seen + lost_sum) >= events_driven;
        return exp_q.size() == 0;
    endfunction

    task automatic finish_test();
        if (stall_mode && inst_seen + lost_sum != events_driven) begin
            $display("Error %s: expected %0d events, actual %0d", test_name,
                     events_driven, inst_seen + lost_sum);
            test_errors++;
        end
        if (stall_mode && last_was_lost) report_problem("LOST record not followed by an event");
        if (exp_q.size() != 0) report_problem("expected records never arrived");
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
            pass_count++;
        end else begin
            $display("FAIL %s (%0d errors)", test_name, test_errors);
            fail_count++;
        end
        exp_q.delete();
        active = 1'b0;
    endtask

    task automatic print_totals();
        $display("Tests: %0d passed, %0d failed, %0d errors outside tests",
                 pass_count, fail_count, stray_errors);
    endtask

    function automatic bit all_passed();
        return fail_count == 0 && stray_errors == 0 && pass_count > 0;
    endfunction

endmodule

`default_nettype wire

/* tests/trace_tb.sv */
`default_nettype none

module trace_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int stall_delay  = 24;
    localparam int quiet_cycles = 16;
    localparam int wait_limit   = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   trace_ack;
    logic                   trace_req;
    trace_pkg::retire_t     retire;
    trace_pkg::trace_rec_t  trace_rec;
    logic [31:0]            rnd_state;
    int                     ack_delay;

    trace_pkg::retire_t     ent_ret [$];
    bit                     ent_gap [$];   // Wait for an idle port first.
    string                  t_name  [$];
    bit                     t_stall [$];
    int                     t_first [$];
    int                     t_count [$];

    trace_top trace_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire    (retire),
        .trace_req (trace_req),
        .trace_ack (trace_ack),
        .trace_rec (trace_rec)
    );

    trace_checker trace_checker_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .retire    (retire),
        .trace_req (trace_req),
        .trace_ack (trace_ack),
        .trace_rec (trace_rec)
    );

    bind trace_top trace_props trace_props_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .trace_req (trace_req),
        .trace_ack (trace_ack),
        .trace_rec (trace_rec),
        .push      (evt_push),
        .pop       (pop)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic trace_pkg::retire_t idle_retire(input logic halted);
        trace_pkg::retire_t r;
        r = '0;
        r.halted = halted;
        return r;
    endfunction

    function automatic trace_pkg::retire_t inst_retire(input logic [31:0] pc,
                                                       input logic [31:0] inst,
                                                       input logic [1:0] prv, input logic dbg);
        trace_pkg::retire_t r;
        r = '0;
        r.valid = 1'b1;
        r.pc = pc;
        r.inst = inst;
        r.prv = prv;
        r.dbg = dbg;
        return r;
    endfunction

    task automatic new_test(input string name, input bit stall);
        t_name.push_back(name);
        t_stall.push_back(stall);
        t_first.push_back(ent_ret.size());
        t_count.push_back(0);
    endtask

    task automatic add_entry(input trace_pkg::retire_t r, input bit gap);
        ent_ret.push_back(r);
        ent_gap.push_back(gap);
        t_count[t_count.size()-1]++;
    endtask

    task automatic build_table();
        trace_pkg::retire_t r;
        new_test("idle_cycles", 1'b0);
        add_entry(idle_retire(1'b0), 1'b0);
        r = idle_retire(1'b0);
        r.mem_req = 1'b1;   // Memory access without a retire.
        r.mem_addr = 32'h40;
        add_entry(r, 1'b0);
        new_test("plain_inst", 1'b0);
        add_entry(inst_retire(32'h100, 32'h00000013, 2'd3, 1'b0), 1'b0);
        add_entry(inst_retire(32'h104, 32'h00a00093, 2'd0, 1'b0), 1'b0);
        add_entry(inst_retire(32'h108, 32'h00100073, 2'd1, 1'b1), 1'b0);
        new_test("load_store", 1'b0);
        r = inst_retire(32'h200, 32'h0031a283, 2'd3, 1'b0);
        r.mem_req = 1'b1;
        r.mem_byte = 4'b0110;
        r.mem_addr = 32'h1003;
        r.mem_rdata = 32'hdeadbeef;
        r.mem_wdata = 32'h11111111;
        r.rd_wr = 1'b1;
        r.rd_addr = 5'd5;
        r.rd_data = 32'h0000adbe;
        add_entry(r, 1'b0);
        r = inst_retire(32'h204, 32'h00532423, 2'd0, 1'b0);
        r.mem_req = 1'b1;
        r.mem_wr = 1'b1;
        r.mem_byte = 4'b1111;
        r.mem_addr = 32'h2008;
        r.mem_rdata = 32'h77777777;
        r.mem_wdata = 32'hcafef00d;
        add_entry(r, 1'b0);
        new_test("reg_csr", 1'b0);
        r = inst_retire(32'h300, 32'h07b00013, 2'd3, 1'b0);
        r.rd_wr = 1'b1;
        r.rd_data = 32'h12345678;   // Written to x0.
        add_entry(r, 1'b0);
        r = inst_retire(32'h304, 32'h0a500513, 2'd3, 1'b0);
        r.rd_wr = 1'b1;
        r.rd_addr = 5'd10;
        r.rd_data = 32'h0000a5a5;
        add_entry(r, 1'b0);
        r = inst_retire(32'h308, 32'h30029073, 2'd3, 1'b0);
        r.csr_wr = 1'b1;
        r.csr_addr = 12'h300;
        r.csr_wdata = 32'h00001888;
        add_entry(r, 1'b0);
        new_test("traps", 1'b0);
        r = inst_retire(32'h400, 32'hffffffff, 2'd0, 1'b0);
        r.csr_wr = 1'b1;
        r.csr_addr = 12'h341;
        r.csr_wdata = 32'h00000400;
        r.trap = 1'b1;
        r.mcause = 32'h00000002;
        r.mtval = 32'hffffffff;
        add_entry(r, 1'b0);
        r = idle_retire(1'b0);
        r.trap = 1'b1;
        r.mcause = 32'h80000007;   // Machine timer interrupt.
        add_entry(r, 1'b0);
        new_test("halt_edges", 1'b0);
        add_entry(idle_retire(1'b1), 1'b0);
        r = inst_retire(32'h800, 32'h00100073, 2'd3, 1'b1);
        r.halted = 1'b1;
        add_entry(r, 1'b0);
        add_entry(idle_retire(1'b0), 1'b0);
        new_test("stall_drop", 1'b1);
        for (int i = 0; i < 8; i++) begin
            add_entry(inst_retire(32'h900 + 32'(4 * i), 32'h00000013, 2'd3, 1'b0), 1'b0);
        end
        add_entry(inst_retire(32'ha00, 32'h00000013, 2'd3, 1'b0), 1'b1);
    endtask

    // Returns once trace_req has stayed low for quiet_cycles cycles.
    task automatic wait_quiet();
        int low_run;
        int cycles;
        low_run = 0;
        cycles = 0;
        while (low_run < quiet_cycles && cycles < wait_limit) begin
            @(negedge clk);
            cycles++;
            low_run = trace_req ? 0 : low_run + 1;
        end
        if (low_run < quiet_cycles) trace_checker_inst.report_problem("trace port never went idle");
    endtask

    task automatic wait_records();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!trace_checker_inst.records_done() && cycles < wait_limit);
        if (!trace_checker_inst.records_done())
            trace_checker_inst.report_problem("timed out waiting for trace records");
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : ack_responder
        int  waited;
        int  d;
        bit  seen;
        trace_ack = 1'b0;
        forever begin
            seen = 1'b0;
            waited = 0;
            while (!seen && waited < wait_limit) begin
                @(posedge clk);
                waited++;
                seen = trace_req;
            end
            if (seen) begin
                for (d = 0; d < ack_delay; d++) @(posedge clk);
                trace_ack <= 1'b1;
                waited = 0;
                while (seen && waited < wait_limit) begin
                    @(posedge clk);
                    waited++;
                    seen = trace_req;
                end
                if (seen) trace_checker_inst.report_problem("trace_req did not drop after ack");
                trace_ack <= 1'b0;
            end
        end
    end

    initial begin : main_flow
        logic last_halted;
        int   t;
        int   e;
        retire = '0;
        rst_n = 1'b0;
        rnd_state = 32'd4;
        ack_delay = 0;
        last_halted = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        for (t = 0; t < t_name.size(); t++) begin
            rnd_state = xorshift32(rnd_state);
            ack_delay = t_stall[t] ? stall_delay : int'(rnd_state % 32'd4);
            @(negedge clk);
            trace_checker_inst.start_test(t_name[t], t_stall[t]);
            if (trace_req !== 1'b0) trace_checker_inst.report_problem("trace_req high at test start");
            for (e = t_first[t]; e < t_first[t] + t_count[t]; e++) begin
                if (ent_gap[e]) begin
                    @(posedge clk);
                    retire <= idle_retire(last_halted);
                    wait_quiet();
                end
                @(posedge clk);
                retire <= ent_ret[e];
                last_halted = ent_ret[e].halted;
            end
            @(posedge clk);
            retire <= idle_retire(last_halted);
            wait_records();
            wait_quiet();
            trace_checker_inst.finish_test();
        end
        trace_checker_inst.print_totals();
        if (trace_checker_inst.all_passed()) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
hw/trace_pkg.sv
hw/retire_capture.sv
hw/event_queue.sv
hw/trace_counters.sv
hw/record_sequencer.sv
hw/trace_port.sv
hw/trace_top.sv
tests/trace_props.sv
tests/trace_checker.sv
tests/trace_tb.sv

/* run.sh */
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trace_tb -f flist.f \
    --Mdir obj_dir -o trace_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/trace_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
